// File: Bender.yml
package:
  name: mmu

export_include_dirs:
  - verilog

sources:
  - verilog/mmu_pkg.sv
  - verilog/mmu_tlb.sv
  - verilog/mmu_ptw.sv
  - verilog/mmu_top.sv
  - target: test
    files:
      - tb/mmu_sva.sv
      - tb/mmu_tb.sv

// File: tb/mmu_sva.sv
`default_nettype none

module mmu_sva (
	input logic                clk,
	input logic                rst_n,
	input logic                rsp_valid,
	input logic                mem_rd,
	input logic                mem_rvalid,
	input mmu_pkg::top_state_t state
);

	timeunit 1ns;
	timeprecision 1ps;

	logic read_pending; // A read has gone out and its data is still due

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			read_pending <= 1'b0;
		end else if (mem_rd) begin
			read_pending <= 1'b1;
		end else if (mem_rvalid) begin
			read_pending <= 1'b0;
		end
	end

	rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |=> !rsp_valid)
		else $error("rsp_valid was high on two consecutive cycles");

	read_in_walk: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd |-> (state == mmu_pkg::top_walk))
		else $error("mem_rd was raised outside a page table walk");

	read_single: assert property (@(posedge clk) disable iff (!rst_n)
		mem_rd |-> !read_pending)
		else $error("A second mem_rd came before mem_rvalid");

endmodule

bind mmu_top mmu_sva mmu_sva_inst (
	.clk        (clk),
	.rst_n      (rst_n),
	.rsp_valid  (rsp_valid),
	.mem_rd     (mem_rd),
	.mem_rvalid (mem_rvalid),
	.state      (state)
);

`default_nettype wire

// File: tb/mmu_tb.sv
`default_nettype none

`include "mmu_macros.svh"

module mmu_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int num_requests = 35;
	localparam int mem_words = 16384;
	localparam logic [21:0] root_ppn = 22'h8;
	localparam logic [21:0] table_a = 22'h9;
	localparam logic [21:0] table_b = 22'ha;

	localparam logic [7:0] f_v = 8'd1 << `MMU_PTE_V;
	localparam logic [7:0] f_r = 8'd1 << `MMU_PTE_R;
	localparam logic [7:0] f_w = 8'd1 << `MMU_PTE_W;
	localparam logic [7:0] f_x = 8'd1 << `MMU_PTE_X;
	localparam logic [7:0] f_a = 8'd1 << `MMU_PTE_A;
	localparam logic [7:0] f_d = 8'd1 << `MMU_PTE_D;
	localparam logic [7:0] f_all = f_v | f_r | f_w | f_x | f_a | f_d;

	logic             clk;
	logic             rst_n;
	logic             req;
	logic [31:0]      vaddr;
	mmu_pkg::access_t access;
	logic             satp_mode;
	logic [21:0]      satp_root_ppn;
	logic             invalidate;
	logic             rsp_valid;
	logic [33:0]      paddr;
	logic             fault;
	logic             mem_rd;
	logic [33:0]      mem_addr;
	logic             mem_rvalid;
	logic [31:0]      mem_rdata;

	logic [31:0] page_mem [mem_words];
	integer      seed = 32'h1a0b_07e9;
	int          cycle = 0;
	int          req_cycle;
	int          sent_count = 0;
	int          rsp_count = 0;
	int          check_count = 0;
	int          error_count = 0;

	string       exp_name [$];
	logic [34:0] exp_result [$]; // Fault bit above the physical address
	bit          exp_fast [$];

	mmu_top mmu_top_inst (
		.clk           (clk),
		.rst_n         (rst_n),
		.req           (req),
		.vaddr         (vaddr),
		.access        (access),
		.satp_mode     (satp_mode),
		.satp_root_ppn (satp_root_ppn),
		.invalidate    (invalidate),
		.rsp_valid     (rsp_valid),
		.paddr         (paddr),
		.fault         (fault),
		.mem_rd        (mem_rd),
		.mem_addr      (mem_addr),
		.mem_rvalid    (mem_rvalid),
		.mem_rdata     (mem_rdata)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) cycle <= cycle + 1;

	function automatic logic [31:0] make_pte(input logic [21:0] ppn, input logic [7:0] flags);
		return {ppn, 2'b00, flags};
	endfunction

	function automatic logic [31:0] make_vaddr(input logic [9:0] vpn1, input logic [9:0] vpn0,
		input logic [11:0] offset);
		return {vpn1, vpn0, offset};
	endfunction

	function automatic logic [31:0] read_word(input logic [33:0] addr);
		if (addr >= 34'h10000) begin
			return 32'h0; // Nothing mapped up there, so the entry is invalid
		end
		return page_mem[addr[15:2]];
	endfunction

	function automatic logic [34:0] translate_ref(input logic [31:0] va,
		input mmu_pkg::access_t acc, input logic paging, input logic [21:0] root);
		logic [31:0] pte;
		logic [21:0] ppn;
		logic        ok;
		if (!paging) begin
			return {1'b0, 2'b00, va};
		end
		pte = read_word({root, va[31:22], 2'b00});
		if (!pte[`MMU_PTE_V] || (pte[`MMU_PTE_W] && !pte[`MMU_PTE_R])) begin
			return {1'b1, 34'd0};
		end
		if (pte[`MMU_PTE_R] || pte[`MMU_PTE_X]) begin
			if (pte[19:10] != 10'd0) begin
				return {1'b1, 34'd0}; // Megapage must be aligned
			end
			ppn = {pte[31:20], va[21:12]};
		end else begin
			pte = read_word({pte[31:10], va[21:12], 2'b00});
			if (!pte[`MMU_PTE_V] || (pte[`MMU_PTE_W] && !pte[`MMU_PTE_R]) ||
				!(pte[`MMU_PTE_R] || pte[`MMU_PTE_X])) begin
				return {1'b1, 34'd0};
			end
			ppn = pte[31:10];
		end
		case (acc)
			mmu_pkg::access_load:  ok = pte[`MMU_PTE_R];
			mmu_pkg::access_store: ok = pte[`MMU_PTE_W] && pte[`MMU_PTE_D];
			mmu_pkg::access_fetch: ok = pte[`MMU_PTE_X];
			default:               ok = 1'b0;
		endcase
		ok = ok && pte[`MMU_PTE_A];
		return {!ok, ppn, va[11:0]};
	endfunction

	task automatic check_value(input string what, input logic [63:0] expected,
		input logic [63:0] actual);
		check_count++;
		if (expected !== actual) begin
			error_count++;
			$display("ERROR %s: expected %h, actual %h", what, expected, actual);
		end
	endtask

	task automatic write_pte(input logic [21:0] table_ppn, input logic [9:0] index,
		input logic [31:0] value);
		logic [33:0] addr;
		addr = {table_ppn, index, 2'b00};
		page_mem[addr[15:2]] = value;
	endtask

	task automatic send_request(input string name, input logic [31:0] va,
		input mmu_pkg::access_t acc, input bit fast);
		exp_name.push_back(name);
		exp_result.push_back(translate_ref(va, acc, satp_mode, satp_root_ppn));
		exp_fast.push_back(fast);
		sent_count++;
		@(posedge clk);
		#2;
		req = 1'b1;
		vaddr = va;
		access = acc;
		req_cycle = cycle;
		@(posedge clk);
		#2;
		req = 1'b0;
		wait (rsp_count == sent_count);
	endtask

	task automatic pulse_invalidate();
		@(posedge clk);
		#2;
		invalidate = 1'b1;
		@(posedge clk);
		#2;
		invalidate = 1'b0;
	endtask

	task automatic report_test(input string name, input int errors_before);
		$display("%s: %s", name, (error_count == errors_before) ? "passed" : "failed");
	endtask

	initial begin : memory_model
		logic [33:0] addr;
		int          delay;
		mem_rvalid = 1'b0;
		mem_rdata = 32'h0;
		forever begin
			@(negedge clk);
			if (mem_rd) begin
				addr = mem_addr;
				delay = 1 + ($unsigned($random(seed)) % 4);
				repeat (delay) @(posedge clk);
				#2;
				mem_rvalid = 1'b1;
				mem_rdata = read_word(addr);
				@(posedge clk);
				#2;
				mem_rvalid = 1'b0;
			end
		end
	end

	initial begin : compare_responses
		string       name;
		logic [34:0] expected;
		bit          fast;
		forever begin
			@(negedge clk);
			if (rsp_valid) begin
				if (exp_name.size() == 0) begin
					error_count++;
					$display("A response arrived with no request outstanding");
				end else begin
					name = exp_name.pop_front();
					expected = exp_result.pop_front();
					fast = exp_fast.pop_front();
					check_value({name, " paddr"}, 64'(expected[33:0]), 64'(paddr));
					check_value({name, " fault"}, 64'(expected[34]), 64'(fault));
					if (fast) begin
						check_value({name, " latency"}, 64'd2, 64'(cycle - req_cycle));
					end
				end
				rsp_count++;
			end
		end
	end

	initial begin : watchdog
		repeat (num_requests * 40) @(posedge clk);
		$display("The run timed out with %0d of %0d responses received", rsp_count, sent_count);
		$display("Test FAILED");
		$finish;
	end

	initial begin : run_tests
		int         errors_before;
		logic [1:0] acc_bits;
		req = 1'b0;
		vaddr = 32'h0;
		access = mmu_pkg::access_load;
		satp_mode = 1'b0;
		satp_root_ppn = root_ppn;
		invalidate = 1'b0;
		rst_n = 1'b0;
		for (int i = 0; i < mem_words; i++) begin
			page_mem[i] = i * 32'h9e37_79b8; // Low bits stay zero so V is clear
		end
		write_pte(root_ppn, 10'd1, make_pte(table_a, f_v));
		write_pte(root_ppn, 10'd2, make_pte(table_b, f_v));
		write_pte(root_ppn, 10'd3, make_pte(22'h1400, f_all));
		write_pte(root_ppn, 10'd4, make_pte(22'h1401, f_all));
		write_pte(root_ppn, 10'd5, make_pte(22'h1800, f_r | f_x | f_a));
		write_pte(root_ppn, 10'd6, make_pte(table_a, f_v | f_w));
		write_pte(table_a, 10'h01, make_pte(22'h12345, f_all));
		write_pte(table_a, 10'h02, make_pte(22'h00777, f_v | f_r | f_a));
		write_pte(table_a, 10'h03, make_pte(22'h3ffff0, f_v | f_r | f_w | f_a));
		write_pte(table_a, 10'h04, make_pte(22'h00404, f_v | f_x | f_a));
		write_pte(table_a, 10'h05, make_pte(22'h00505, f_v | f_r | f_w | f_x | f_d));
		write_pte(table_a, 10'h06, make_pte(22'h00606, f_v | f_w | f_x | f_a | f_d));
		write_pte(table_a, 10'h07, make_pte(22'h00707, f_r | f_x | f_a));
		write_pte(table_a, 10'h08, make_pte(table_b, f_v));
		write_pte(table_b, 10'h02, make_pte(22'h01f00, f_v | f_x | f_a));
		write_pte(table_b, 10'h05, make_pte(22'h0abcd, f_all));
		write_pte(table_b, 10'h21, make_pte(22'h02121, f_all));
		write_pte(table_b, 10'h31, make_pte(22'h03131, f_all));
		repeat (2) @(posedge clk);
		#2;
		rst_n = 1'b1;

		errors_before = error_count;
		for (int i = 0; i < 8; i++) begin
			acc_bits = 2'($unsigned($random(seed)) % 3);
			send_request("bare", $random(seed), mmu_pkg::access_t'(acc_bits), 1'b1);
		end
		report_test("bare mode pass-through", errors_before);

		@(posedge clk);
		#2;
		satp_mode = 1'b1;
		errors_before = error_count;
		send_request("4k walk", make_vaddr(1, 10'h01, 12'h123), mmu_pkg::access_load, 1'b0);
		send_request("4k hit", make_vaddr(1, 10'h01, 12'habc), mmu_pkg::access_store, 1'b1);
		send_request("4k fetch walk", make_vaddr(2, 10'h02, 12'h010), mmu_pkg::access_fetch, 1'b0);
		send_request("4k fetch hit", make_vaddr(2, 10'h02, 12'hff4), mmu_pkg::access_fetch, 1'b1);
		report_test("4 KiB pages", errors_before);

		errors_before = error_count;
		send_request("mega low", make_vaddr(3, 10'h000, 12'h004), mmu_pkg::access_load, 1'b0);
		send_request("mega mid", make_vaddr(3, 10'h155, 12'h7a8), mmu_pkg::access_store, 1'b0);
		send_request("mega top", make_vaddr(3, 10'h3ff, 12'hffc), mmu_pkg::access_fetch, 1'b0);
		send_request("mega misaligned", make_vaddr(4, 10'h010, 12'h0), mmu_pkg::access_load, 1'b0);
		report_test("megapages", errors_before);

		errors_before = error_count;
		send_request("load with r", make_vaddr(1, 10'h02, 12'h100), mmu_pkg::access_load, 1'b0);
		send_request("store without w", make_vaddr(1, 10'h02, 12'h104), mmu_pkg::access_store, 1'b0);
		send_request("fetch without x", make_vaddr(1, 10'h02, 12'h108), mmu_pkg::access_fetch, 1'b0);
		send_request("store without d", make_vaddr(1, 10'h03, 12'h200), mmu_pkg::access_store, 1'b0);
		send_request("fetch with x", make_vaddr(1, 10'h04, 12'h300), mmu_pkg::access_fetch, 1'b0);
		send_request("load without r", make_vaddr(1, 10'h04, 12'h304), mmu_pkg::access_load, 1'b0);
		send_request("load without a", make_vaddr(1, 10'h05, 12'h400), mmu_pkg::access_load, 1'b0);
		send_request("leaf w without r", make_vaddr(1, 10'h06, 12'h0), mmu_pkg::access_fetch, 1'b0);
		send_request("leaf invalid", make_vaddr(1, 10'h07, 12'h0), mmu_pkg::access_load, 1'b0);
		send_request("pointer at l0", make_vaddr(1, 10'h08, 12'h0), mmu_pkg::access_load, 1'b0);
		send_request("l1 invalid", make_vaddr(5, 10'h001, 12'h0), mmu_pkg::access_fetch, 1'b0);
		send_request("l1 w without r", make_vaddr(6, 10'h001, 12'h0), mmu_pkg::access_store, 1'b0);
		report_test("permission faults", errors_before);

		errors_before = error_count;
		send_request("before remap", make_vaddr(2, 10'h05, 12'h050), mmu_pkg::access_load, 1'b0);
		send_request("cached remap", make_vaddr(2, 10'h05, 12'h054), mmu_pkg::access_load, 1'b1);
		write_pte(table_b, 10'h05, make_pte(22'h0dcba, f_all));
		pulse_invalidate();
		send_request("after remap", make_vaddr(2, 10'h05, 12'h058), mmu_pkg::access_load, 1'b0);
		report_test("invalidate", errors_before);

		errors_before = error_count;
		send_request("evict first", make_vaddr(2, 10'h21, 12'h111), mmu_pkg::access_load, 1'b0);
		send_request("evict second", make_vaddr(2, 10'h31, 12'h222), mmu_pkg::access_store, 1'b0);
		send_request("evict first again", make_vaddr(2, 10'h21, 12'h333), mmu_pkg::access_fetch, 1'b0);
		send_request("evict second again", make_vaddr(2, 10'h31, 12'h444), mmu_pkg::access_load, 1'b0);
		report_test("index conflict", errors_before);

		if (exp_name.size() != 0) begin
			error_count++;
			$display("%0d expected responses never arrived", exp_name.size());
		end
		$display("%0d requests, %0d checks, %0d errors", sent_count, check_count, error_count);
		if (error_count == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+verilog
verilog/mmu_pkg.sv
verilog/mmu_tlb.sv
verilog/mmu_ptw.sv
verilog/mmu_top.sv
tb/mmu_sva.sv
tb/mmu_tb.sv

// File: verilog/mmu_macros.svh
`ifndef MMU_MACROS_SVH
`define MMU_MACROS_SVH

`define MMU_TLB_ENTRIES 16

`define MMU_VA_W 32
`define MMU_PA_W 34
`define MMU_PPN_W 22
`define MMU_VPN_W 20
`define MMU_OFFSET_W 12

// Bit positions inside a page table entry
`define MMU_PTE_V 0
`define MMU_PTE_R 1
`define MMU_PTE_W 2
`define MMU_PTE_X 3
`define MMU_PTE_U 4
`define MMU_PTE_G 5
`define MMU_PTE_A 6
`define MMU_PTE_D 7

`endif

// File: verilog/mmu_pkg.sv
`default_nettype none

package mmu_pkg;

	typedef enum logic [1:0] {
		access_load  = 2'd0,
		access_store = 2'd1,
		access_fetch = 2'd2
	} access_t;

	typedef enum logic [2:0] {
		walk_idle    = 3'd0,
		walk_l1_req  = 3'd1,
		walk_l1_wait = 3'd2,
		walk_l0_req  = 3'd3,
		walk_l0_wait = 3'd4,
		walk_done    = 3'd5
	} walk_state_t;

	typedef enum logic [2:0] {
		top_idle    = 3'd0,
		top_lookup  = 3'd1,
		top_walk    = 3'd2,
		top_retry   = 3'd3,
		top_respond = 3'd4
	} top_state_t;

endpackage

`default_nettype wire

// File: verilog/mmu_ptw.sv
`default_nettype none

`include "mmu_macros.svh"

module mmu_ptw (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  walk_start,
	input  logic [`MMU_VPN_W-1:0] vpn,
	input  logic [`MMU_PPN_W-1:0] root_ppn,

	output logic                  mem_rd,
	output logic [`MMU_PA_W-1:0]  mem_addr,
	input  logic                  mem_rvalid,
	input  logic [31:0]           mem_rdata,

	output logic                  walk_done,
	output logic                  walk_fault,
	output logic [`MMU_PPN_W-1:0] walk_ppn,
	output logic [7:0]            walk_tag
);

	mmu_pkg::walk_state_t  state;

	logic [`MMU_VPN_W-1:0] vpn_r;
	logic [`MMU_PPN_W-1:0] table_ppn; // Base of the table being read
	logic                  level1;
	logic [9:0]            vpn_part;
	logic                  rsp_in;

	logic                  pte_v;
	logic                  pte_r;
	logic                  pte_w;
	logic                  pte_x;
	logic                  pte_bad;
	logic                  pte_leaf;
	logic                  pte_misaligned;
	logic [`MMU_PPN_W-1:0] pte_ppn;

	logic                  fault_next;
	logic [`MMU_PPN_W-1:0] ppn_next;

	assign level1 = (state == mmu_pkg::walk_l1_req) || (state == mmu_pkg::walk_l1_wait);
	assign vpn_part = level1 ? vpn_r[19:10] : vpn_r[9:0];

	// Entries are four bytes wide
	assign mem_addr = {table_ppn, vpn_part, 2'b00};
	assign mem_rd = (state == mmu_pkg::walk_l1_req) || (state == mmu_pkg::walk_l0_req);
	assign walk_done = (state == mmu_pkg::walk_done);

	assign rsp_in = mem_rvalid &&
		((state == mmu_pkg::walk_l1_wait) || (state == mmu_pkg::walk_l0_wait));

	assign pte_v   = mem_rdata[`MMU_PTE_V];
	assign pte_r   = mem_rdata[`MMU_PTE_R];
	assign pte_w   = mem_rdata[`MMU_PTE_W];
	assign pte_x   = mem_rdata[`MMU_PTE_X];
	assign pte_ppn = mem_rdata[31:10];

	assign pte_bad        = !pte_v || (pte_w && !pte_r);
	assign pte_leaf       = pte_r || pte_x;
	assign pte_misaligned = (mem_rdata[19:10] != 10'd0);

	always_comb begin
		fault_next = pte_bad;
		ppn_next   = pte_ppn;
		if (level1) begin
			// A megapage keeps the low page number bits of the request
			fault_next = pte_bad || (pte_leaf && pte_misaligned);
			ppn_next   = {pte_ppn[21:10], vpn_r[9:0]};
		end else if (!pte_leaf) begin
			fault_next = 1'b1; // No third level in Sv32
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= mmu_pkg::walk_idle;
		end else begin
			case (state)
				mmu_pkg::walk_idle: begin
					if (walk_start) begin
						state <= mmu_pkg::walk_l1_req;
					end
				end
				mmu_pkg::walk_l1_req: begin
					state <= mmu_pkg::walk_l1_wait;
				end
				mmu_pkg::walk_l1_wait: begin
					if (mem_rvalid) begin
						if (pte_bad || pte_leaf) begin
							state <= mmu_pkg::walk_done;
						end else begin
							state <= mmu_pkg::walk_l0_req;
						end
					end
				end
				mmu_pkg::walk_l0_req: begin
					state <= mmu_pkg::walk_l0_wait;
				end
				mmu_pkg::walk_l0_wait: begin
					if (mem_rvalid) begin
						state <= mmu_pkg::walk_done;
					end
				end
				mmu_pkg::walk_done: begin
					state <= mmu_pkg::walk_idle;
				end
				default: begin
					state <= mmu_pkg::walk_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == mmu_pkg::walk_idle) && walk_start) begin
			vpn_r     <= vpn;
			table_ppn <= root_ppn;
		end
		if (rsp_in) begin
			walk_fault <= fault_next;
			walk_ppn   <= ppn_next;
			walk_tag   <= mem_rdata[7:0];
			if (level1 && !pte_bad && !pte_leaf) begin
				table_ppn <= pte_ppn; // Follow the pointer down to level 0
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/mmu_tlb.sv
`default_nettype none

`include "mmu_macros.svh"

module mmu_tlb #(
	parameter int ENTRIES = `MMU_TLB_ENTRIES
) (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  enable,
	input  logic [`MMU_VPN_W-1:0] virtual_address,

	input  logic                  invalidate,
	input  logic                  resolve,
	input  logic                  write,

	input  logic [`MMU_VPN_W-1:0] virtual_address_w,
	input  logic [7:0]            accesstag_w,
	input  logic [`MMU_PPN_W-1:0] phys_w,

	output logic                  miss,
	output logic                  done,
	output logic [7:0]            accesstag_r,
	output logic [`MMU_PPN_W-1:0] phys_r
);

	localparam int ENTRIES_W = $clog2(ENTRIES);
	localparam int TAG_W = `MMU_VPN_W - ENTRIES_W;

	// Bare mode grants everything and is not global
	localparam logic [7:0] BARE_TAG = ~(8'd1 << `MMU_PTE_G);

	logic [ENTRIES_W-1:0]  set_index;
	logic [ENTRIES_W-1:0]  set_index_w;
	logic [TAG_W-1:0]      virt_tag;
	logic [TAG_W-1:0]      virt_tag_w;

	logic [ENTRIES-1:0]    valid;
	logic [7:1]            accesstag [ENTRIES];
	logic [TAG_W-1:0]      tag       [ENTRIES];
	logic [`MMU_PPN_W-1:0] phys      [ENTRIES];

	logic [ENTRIES_W-1:0]  set_index_r;
	logic [TAG_W-1:0]      virt_tag_r;
	logic                  enable_r;
	logic                  resolve_r;
	logic                  hit;

	// Low page number bits pick the entry, the rest is compared
	assign set_index   = virtual_address[ENTRIES_W-1:0];
	assign virt_tag    = virtual_address[`MMU_VPN_W-1:ENTRIES_W];
	assign set_index_w = virtual_address_w[ENTRIES_W-1:0];
	assign virt_tag_w  = virtual_address_w[`MMU_VPN_W-1:ENTRIES_W];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			valid     <= '0;
			resolve_r <= 1'b0;
			enable_r  <= 1'b0;
		end else begin
			resolve_r <= resolve;
			if (resolve) begin
				enable_r <= enable;
			end else if (write) begin
				valid[set_index_w] <= accesstag_w[`MMU_PTE_V];
			end else if (invalidate) begin
				valid <= '0; // Flush every entry
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resolve) begin
			set_index_r <= set_index;
			virt_tag_r  <= virt_tag;
		end else if (write) begin
			accesstag[set_index_w] <= accesstag_w[7:1];
			tag[set_index_w]       <= virt_tag_w;
			phys[set_index_w]      <= phys_w;
		end
	end

	assign hit  = valid[set_index_r] && (tag[set_index_r] == virt_tag_r);
	assign done = resolve_r;
	assign miss = resolve_r && enable_r && !hit;

	always_comb begin
		if (enable_r) begin
			phys_r      = phys[set_index_r];
			accesstag_r = {accesstag[set_index_r], valid[set_index_r]};
		end else begin
			// Index and tag together give back the page number
			phys_r      = {{(`MMU_PPN_W - `MMU_VPN_W){1'b0}}, virt_tag_r, set_index_r};
			accesstag_r = BARE_TAG;
		end
	end

endmodule

`default_nettype wire

// File: verilog/mmu_top.sv
`default_nettype none

`include "mmu_macros.svh"

module mmu_top (
	input  logic                  clk,
	input  logic                  rst_n,

	input  logic                  req,
	input  logic [`MMU_VA_W-1:0]  vaddr,
	input  mmu_pkg::access_t      access,
	input  logic                  satp_mode,
	input  logic [`MMU_PPN_W-1:0] satp_root_ppn,
	input  logic                  invalidate,

	output logic                  rsp_valid,
	output logic [`MMU_PA_W-1:0]  paddr,
	output logic                  fault,

	output logic                  mem_rd,
	output logic [`MMU_PA_W-1:0]  mem_addr,
	input  logic                  mem_rvalid,
	input  logic [31:0]           mem_rdata
);

	mmu_pkg::top_state_t   state;
	logic [`MMU_VA_W-1:0]  vaddr_r;
	mmu_pkg::access_t      access_r;

	logic                  idle;
	logic                  accept;
	logic                  hit;
	logic                  perm_ok;

	logic                  tlb_resolve;
	logic                  tlb_write;
	logic                  tlb_invalidate;
	logic [`MMU_VPN_W-1:0] tlb_vpn;
	logic                  tlb_miss;
	logic                  tlb_done;
	logic [7:0]            tlb_tag;
	logic [`MMU_PPN_W-1:0] tlb_phys;

	logic                  walk_start;
	logic                  walk_done;
	logic                  walk_fault;
	logic [`MMU_PPN_W-1:0] walk_ppn;
	logic [7:0]            walk_tag;

	assign idle   = (state == mmu_pkg::top_idle);
	assign accept = idle && req;
	assign hit    = (state == mmu_pkg::top_lookup) && tlb_done && !tlb_miss;

	// The first lookup uses the live address so a hit answers in two cycles
	assign tlb_vpn        = idle ? vaddr[`MMU_VA_W-1:`MMU_OFFSET_W]
		: vaddr_r[`MMU_VA_W-1:`MMU_OFFSET_W];
	assign tlb_resolve    = accept || (state == mmu_pkg::top_retry);
	assign tlb_invalidate = idle && invalidate;
	assign tlb_write      = (state == mmu_pkg::top_walk) && walk_done && !walk_fault;
	assign walk_start     = (state == mmu_pkg::top_lookup) && tlb_done && tlb_miss;
	assign rsp_valid      = (state == mmu_pkg::top_respond);

	always_comb begin
		case (access_r)
			mmu_pkg::access_load:  perm_ok = tlb_tag[`MMU_PTE_R];
			mmu_pkg::access_store: perm_ok = tlb_tag[`MMU_PTE_W] && tlb_tag[`MMU_PTE_D];
			mmu_pkg::access_fetch: perm_ok = tlb_tag[`MMU_PTE_X];
			default:               perm_ok = 1'b0;
		endcase
		perm_ok = perm_ok && tlb_tag[`MMU_PTE_A];
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= mmu_pkg::top_idle;
		end else begin
			case (state)
				mmu_pkg::top_idle:    if (req) state <= mmu_pkg::top_lookup;
				mmu_pkg::top_lookup: begin
					if (tlb_done) begin
						state <= tlb_miss ? mmu_pkg::top_walk : mmu_pkg::top_respond;
					end
				end
				mmu_pkg::top_walk: begin
					if (walk_done) begin
						state <= walk_fault ? mmu_pkg::top_respond : mmu_pkg::top_retry;
					end
				end
				mmu_pkg::top_retry:   state <= mmu_pkg::top_lookup;
				mmu_pkg::top_respond: state <= mmu_pkg::top_idle;
				default:              state <= mmu_pkg::top_idle;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			vaddr_r  <= vaddr;
			access_r <= access;
		end
		if (hit) begin
			paddr <= {tlb_phys, vaddr_r[`MMU_OFFSET_W-1:0]};
			fault <= !perm_ok;
		end else if ((state == mmu_pkg::top_walk) && walk_done && walk_fault) begin
			paddr <= '0;
			fault <= 1'b1;
		end
	end

	mmu_tlb #(
		.ENTRIES(`MMU_TLB_ENTRIES)
	) tlb_inst (
		.clk               (clk),
		.rst_n             (rst_n),
		.enable            (satp_mode),
		.virtual_address   (tlb_vpn),
		.invalidate        (tlb_invalidate),
		.resolve           (tlb_resolve),
		.write             (tlb_write),
		.virtual_address_w (vaddr_r[`MMU_VA_W-1:`MMU_OFFSET_W]),
		.accesstag_w       (walk_tag),
		.phys_w            (walk_ppn),
		.miss              (tlb_miss),
		.done              (tlb_done),
		.accesstag_r       (tlb_tag),
		.phys_r            (tlb_phys)
	);

	mmu_ptw ptw_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.walk_start (walk_start),
		.vpn        (vaddr_r[`MMU_VA_W-1:`MMU_OFFSET_W]),
		.root_ppn   (satp_root_ppn),
		.mem_rd     (mem_rd),
		.mem_addr   (mem_addr),
		.mem_rvalid (mem_rvalid),
		.mem_rdata  (mem_rdata),
		.walk_done  (walk_done),
		.walk_fault (walk_fault),
		.walk_ppn   (walk_ppn),
		.walk_tag   (walk_tag)
	);

endmodule

`default_nettype wire
